// File: hw/render_pkg.sv
package render_pkg;

	// Worker pool
	localparam int num_workers = 16;

	// Pixel coordinates
	localparam int coord_width = 10;

	// Escape recurrence
	localparam int max_iter = 15;
	localparam int color_width = 4;
	localparam int seed_width = 8;

	typedef logic [coord_width-1:0] coord_t;
	typedef logic [num_workers-1:0] worker_mask_t;
	typedef logic [color_width-1:0] color_t;
	typedef logic [seed_width-1:0] seed_t;

	// Job handed to a worker
	typedef struct packed {
		coord_t x;
		coord_t y;
	} pix_job_t;

	// Finished pixel
	typedef struct packed {
		coord_t x;
		coord_t y;
		color_t color;
	} pix_result_t;

	typedef enum logic [2:0] {
		st_idle,
		st_search,
		st_rest,
		st_assign,
		st_drain
	} disp_state_t;

	typedef enum logic [1:0] {
		wk_idle,
		wk_run,
		wk_done
	} work_state_t;

	// Lowest set bit as a one-hot mask
	function automatic worker_mask_t lowest_one(input worker_mask_t m);
		return m & (~m + 1'b1);
	endfunction

endpackage

// File: hw/pix_inc.sv
module pix_inc
	import render_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic clear,
	input logic inc,
	input coord_t x_max,
	input coord_t y_max,
	output pix_job_t cur,
	output logic last
);

	coord_t x;
	coord_t y;
	logic x_wrap;
	logic y_wrap;

	assign x_wrap = (x == x_max);
	assign y_wrap = (y == y_max);

	// Raster order, x fastest
	always_ff @(posedge clk) begin
		if (n_rst == 1'b0 || clear == 1'b1) begin
			x <= '0;
			y <= '0;
		end else if (inc == 1'b1) begin
			if (x_wrap) begin
				x <= '0;
				if (y_wrap) begin
					y <= '0;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	assign cur.x = x;
	assign cur.y = y;

	// Final pixel of the frame
	assign last = x_wrap && y_wrap;

endmodule

// File: hw/dispatch.sv
module dispatch
	import render_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic start,
	input coord_t x_last,
	input coord_t y_last,
	input worker_mask_t jw_ready,
	output worker_mask_t jw_start,
	output pix_job_t job,
	output logic busy,
	output logic frame_done
);

	disp_state_t state;
	disp_state_t next_state;

	coord_t x_max;
	coord_t y_max;
	pix_job_t cur;
	logic last;
	logic inc;
	logic clear;
	logic any_ready;
	logic all_ready;
	worker_mask_t pick;

	pix_inc u_xy_cnt (
		.clk(clk),
		.n_rst(n_rst),
		.clear(clear),
		.inc(inc),
		.x_max(x_max),
		.y_max(y_max),
		.cur(cur),
		.last(last)
	);

	// New frame only from idle
	assign clear = (state == st_idle) && start;
	assign inc = (state == st_assign);
	assign busy = (state != st_idle);

	assign any_ready = |jw_ready;
	assign all_ready = &jw_ready;

	// Lowest ready worker wins
	assign pick = lowest_one(jw_ready);

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (start) begin
					next_state = st_search;
				end
			end
			st_search: begin
				if (any_ready) begin
					next_state = st_rest;
				end
			end
			// Lets the chosen worker drop ready
			st_rest: begin
				next_state = st_assign;
			end
			st_assign: begin
				if (last) begin
					next_state = st_drain;
				end else begin
					next_state = st_search;
				end
			end
			st_drain: begin
				if (all_ready) begin
					next_state = st_idle;
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (n_rst == 1'b0) begin
			state <= st_idle;
			jw_start <= '0;
			frame_done <= 1'b0;
		end else begin
			state <= next_state;
			jw_start <= (state == st_search) ? pick : '0;
			frame_done <= (state == st_drain) && all_ready;
		end
	end

	// Frame limits and the job word
	always_ff @(posedge clk) begin
		if (clear) begin
			x_max <= x_last;
			y_max <= y_last;
		end
		if (state == st_search && any_ready) begin
			job <= cur;
		end
	end

endmodule

// File: hw/pixel_worker.sv
module pixel_worker
	import render_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic start,
	input pix_job_t job,
	input logic ack,
	output logic ready,
	output logic done,
	output pix_result_t result
);

	work_state_t state;
	work_state_t next_state;

	pix_job_t job_q;
	seed_t c;
	seed_t z;
	seed_t z_nxt;
	color_t steps;
	color_t steps_nxt;
	logic escape;

	// One step of z = z*z + c, kept to 8 bits
	always_comb begin
		z_nxt = seed_t'(z * z) + c;
		steps_nxt = steps + 1'b1;
		escape = z_nxt[seed_width-1] || (steps_nxt == color_t'(max_iter));
	end

	always_comb begin
		next_state = state;
		case (state)
			wk_idle: begin
				if (start) begin
					next_state = wk_run;
				end
			end
			wk_run: begin
				if (escape) begin
					next_state = wk_done;
				end
			end
			wk_done: begin
				if (ack) begin
					next_state = wk_idle;
				end
			end
			default: begin
				next_state = wk_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (n_rst == 1'b0) begin
			state <= wk_idle;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (state == wk_idle && start) begin
			job_q <= job;
			c <= seed_t'(job.x ^ job.y);
			z <= '0;
			steps <= '0;
		end else if (state == wk_run) begin
			z <= z_nxt;
			steps <= steps_nxt;
		end
	end

	assign ready = (state == wk_idle);
	assign done = (state == wk_done);

	// Held until ack
	assign result.x = job_q.x;
	assign result.y = job_q.y;
	assign result.color = steps;

endmodule

// File: hw/result_collector.sv
module result_collector
	import render_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input worker_mask_t done,
	input pix_result_t results [num_workers],
	output worker_mask_t ack,
	output pix_result_t res,
	output logic res_valid
);

	worker_mask_t granted;
	worker_mask_t avail;
	pix_result_t pick;

	// Last grant is still dropping done
	assign avail = done & ~granted;
	assign ack = lowest_one(avail);

	// One-hot mux of the granted result
	always_comb begin
		pick = '0;
		for (int i = 0; i < num_workers; i++) begin
			if (ack[i]) begin
				pick = results[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (n_rst == 1'b0) begin
			granted <= '0;
			res_valid <= 1'b0;
		end else begin
			granted <= ack;
			res_valid <= |ack;
		end
	end

	always_ff @(posedge clk) begin
		if (|ack) begin
			res <= pick;
		end
	end

endmodule

// File: hw/render_top.sv
module render_top
	import render_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input logic start,
	input coord_t x_last,
	input coord_t y_last,
	output pix_result_t res,
	output logic res_valid,
	output logic busy,
	output logic frame_done
);

	worker_mask_t jw_ready;
	worker_mask_t jw_start;
	worker_mask_t jw_done;
	worker_mask_t jw_ack;
	pix_job_t job;
	pix_result_t jw_result [num_workers];

	dispatch u_dispatch (
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.x_last(x_last),
		.y_last(y_last),
		.jw_ready(jw_ready),
		.jw_start(jw_start),
		.job(job),
		.busy(busy),
		.frame_done(frame_done)
	);

	// Worker pool, all share the job word
	generate
		for (genvar i = 0; i < num_workers; i++) begin : g_worker
			pixel_worker u_worker (
				.clk(clk),
				.n_rst(n_rst),
				.start(jw_start[i]),
				.job(job),
				.ack(jw_ack[i]),
				.ready(jw_ready[i]),
				.done(jw_done[i]),
				.result(jw_result[i])
			);
		end
	endgenerate

	result_collector u_collector (
		.clk(clk),
		.n_rst(n_rst),
		.done(jw_done),
		.results(jw_result),
		.ack(jw_ack),
		.res(res),
		.res_valid(res_valid)
	);

endmodule

// File: sim/tb_clock.sv
module tb_clock (
	output logic clk
);

	// Period of 40, starts low
	initial begin
		clk = 1'b0;
	end

	always begin
		#20 clk = ~clk;
	end

endmodule

// File: sim/render_asserts.sv
module render_asserts
	import render_pkg::*;
(
	input logic clk,
	input logic n_rst,
	input worker_mask_t jw_start,
	input worker_mask_t jw_ready,
	input logic frame_done
);

	// At most one worker started per cycle
	start_onehot: assert property (@(posedge clk) disable iff (!n_rst)
		$onehot0(jw_start))
		else $error("jw_start is not one-hot or zero: %h", jw_start);

	start_to_ready: assert property (@(posedge clk) disable iff (!n_rst)
		(jw_start & ~jw_ready) == '0)
		else $error("jw_start %h targets a busy worker, jw_ready %h", jw_start, jw_ready);

	// Frame ends only with the whole pool idle
	done_all_ready: assert property (@(posedge clk) disable iff (!n_rst)
		frame_done |-> (&jw_ready))
		else $error("frame_done with jw_ready %h", jw_ready);

endmodule

bind dispatch render_asserts u_asserts (
	.clk(clk),
	.n_rst(n_rst),
	.jw_start(jw_start),
	.jw_ready(jw_ready),
	.frame_done(frame_done)
);

// File: sim/render_tb.sv
module render_tb
	import render_pkg::*;
();

	typedef struct packed {
		coord_t x_last;
		coord_t y_last;
		coord_t n_pix;
	} frame_t;

	logic clk;
	logic n_rst;
	logic start;
	coord_t x_last;
	coord_t y_last;
	pix_result_t res;
	logic res_valid;
	logic busy;
	logic frame_done;

	frame_t frames [6];
	int hits [int];
	pix_result_t seen [int];
	int res_cnt;
	int done_cnt;
	bit frame_over;
	coord_t lim_x;
	coord_t lim_y;
	int wd_cycles;

	tb_clock u_clock (
		.clk(clk)
	);

	render_top uut (
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.x_last(x_last),
		.y_last(y_last),
		.res(res),
		.res_valid(res_valid),
		.busy(busy),
		.frame_done(frame_done)
	);

	// Escape count of z = z*z + c over 8 bits
	function automatic color_t ref_color(input coord_t x, input coord_t y);
		int c;
		int z;
		int n;
		c = int'(x ^ y) % 256;
		z = 0;
		n = 0;
		do begin
			z = (z * z + c) % 256;
			n = n + 1;
		end while (z < 128 && n < max_iter);
		return color_t'(n);
	endfunction

	function automatic int pix_key(input coord_t x, input coord_t y);
		return {12'd0, x, y};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_result(input string name, input pix_result_t got,
			input pix_result_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// Result monitor on the falling edge
	always @(negedge clk) begin
		int key;
		if (n_rst === 1'b1 && res_valid === 1'b1) begin
			key = pix_key(res.x, res.y);
			if (frame_over) begin
				abort_run("a result arrived after frame_done");
			end else if (res.x > lim_x || res.y > lim_y) begin
				abort_run($sformatf("result at x=%0d y=%0d lies outside the frame",
					res.x, res.y));
			end else if (hits.exists(key)) begin
				hits[key] = hits[key] + 1;
			end else begin
				hits[key] = 1;
			end
			seen[key] = res;
			res_cnt = res_cnt + 1;
		end
		if (n_rst === 1'b1 && frame_done === 1'b1) begin
			done_cnt = done_cnt + 1;
			frame_over = 1'b1;
			if (busy !== 1'b0) begin
				abort_run("busy is still high in the frame_done cycle");
			end
		end
	end

	task automatic run_frame(input frame_t f);
		pix_result_t exp;
		int key;
		int gap;
		int x;
		int y;
		hits.delete();
		seen.delete();
		res_cnt = 0;
		done_cnt = 0;
		frame_over = 1'b0;
		lim_x = f.x_last;
		lim_y = f.y_last;
		x_last = f.x_last;
		y_last = f.y_last;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		repeat (2) @(negedge clk);
		if (busy !== 1'b1) begin
			abort_run("busy did not rise after start");
		end
		// Stray start with other limits
		x_last = 10'd7;
		y_last = 10'd5;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (frame_done !== 1'b1) begin
			@(negedge clk);
		end
		@(negedge clk);
		check_coord("res_valid count", coord_t'(res_cnt), f.n_pix);
		for (x = 0; x <= int'(f.x_last); x++) begin
			for (y = 0; y <= int'(f.y_last); y++) begin
				key = pix_key(coord_t'(x), coord_t'(y));
				if (!hits.exists(key)) begin
					abort_run($sformatf("pixel x=%0d y=%0d was never reported", x, y));
				end
				check_coord("pixel hit count", coord_t'(hits[key]), coord_t'(1));
				exp.x = coord_t'(x);
				exp.y = coord_t'(y);
				exp.color = ref_color(coord_t'(x), coord_t'(y));
				check_result("res", seen[key], exp);
			end
		end
		gap = int'($urandom % 32'd12) + 1;
		repeat (gap) @(negedge clk);
		check_coord("frame_done count", coord_t'(done_cnt), coord_t'(1));
		if (busy !== 1'b0) begin
			abort_run("busy stayed high after frame_done");
		end
	endtask

	initial begin
		int total;
		n_rst = 1'b0;
		start = 1'b0;
		x_last = '0;
		y_last = '0;
		res_cnt = 0;
		done_cnt = 0;
		frame_over = 1'b0;
		lim_x = '0;
		lim_y = '0;
		wd_cycles = 0;
		void'($urandom(32'hf3d9));

		frames[0] = '{x_last: 10'd0, y_last: 10'd0, n_pix: 10'd1};
		frames[1] = '{x_last: 10'd3, y_last: 10'd2, n_pix: 10'd12};
		frames[2] = '{x_last: 10'd15, y_last: 10'd0, n_pix: 10'd16};
		frames[3] = '{x_last: 10'd0, y_last: 10'd7, n_pix: 10'd8};
		frames[4] = '{x_last: 10'd9, y_last: 10'd6, n_pix: 10'd70};
		frames[5] = '{x_last: 10'd31, y_last: 10'd3, n_pix: 10'd128};

		total = 0;
		foreach (frames[i]) begin
			total = total + int'(frames[i].n_pix);
		end
		wd_cycles = total * (max_iter + 8) + 400;

		repeat (3) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		if (busy !== 1'b0 || res_valid !== 1'b0 || frame_done !== 1'b0) begin
			abort_run("outputs are not idle after reset");
		end

		foreach (frames[i]) begin
			run_frame(frames[i]);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

	// Watchdog
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		abort_run($sformatf("timeout after %0d cycles, the frames did not finish",
			wd_cycles));
	end

endmodule

// File: filelist.f
hw/render_pkg.sv
hw/pix_inc.sv
hw/dispatch.sv
hw/pixel_worker.sv
hw/result_collector.sv
hw/render_top.sv
sim/tb_clock.sv
sim/render_asserts.sv
sim/render_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the render testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log
fail_msg='*** TEST FAILED ***'

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module render_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$build_dir/Vrender_tb" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -qF "$fail_msg" "$log"; then
	echo "Simulation reported a failure, see $log"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status, see $log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
